// File: rtl/core_mem_pkg.sv
// Core memory definitions
package core_mem_pkg;

    // physical address of RAM word 0
    localparam logic [63:0] DRAM_BASE = 64'h8000_0000;

    // RAM geometry, 64-bit words
    localparam int unsigned MEM_WORDS = 1024;
    localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

    // byte offset bits inside one 64-bit word
    localparam int unsigned WORD_OFF_W = 3;

    // size of the mapped window in bytes
    localparam int unsigned MEM_BYTES = MEM_WORDS << WORD_OFF_W;

    // data port split address: index is sent with the request
    localparam int unsigned INDEX_W = 12;

    // the tag follows in a later cycle and carries the upper bits
    localparam int unsigned TAG_W = 44;

    // full data physical address
    localparam int unsigned PADDR_W = TAG_W + INDEX_W;

    // instruction fetch address width
    localparam int unsigned IADDR_W = 64;

endpackage

// File: rtl/mem_ram.sv
// Dual-port word RAM
`timescale 1ns/100ps

module mem_ram #(
    parameter int unsigned DEPTH = core_mem_pkg::MEM_WORDS
) (
    input  logic                     clk_i,

    // port a, read only
    input  logic                     a_re_i,
    input  logic [$clog2(DEPTH)-1:0] a_addr_i,
    output logic [63:0]              a_rdata_o,

    // port b, read/write with byte enables
    input  logic                     b_en_i,
    input  logic                     b_we_i,
    input  logic [7:0]               b_be_i,
    input  logic [$clog2(DEPTH)-1:0] b_addr_i,
    input  logic [63:0]              b_wdata_i,
    output logic [63:0]              b_rdata_o
);

    // eight byte lanes per word
    logic [7:0][7:0] mem [DEPTH];

    // simulation model starts from a cleared array
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // port b write, only the enabled lanes change
    always @(posedge clk_i) begin
        if (b_en_i && b_we_i) begin
            for (int i = 0; i < 8; i++) begin
                if (b_be_i[i]) begin
                    mem[b_addr_i][i] <= b_wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // registered reads, a same-cycle write on b is not seen yet
    always_ff @(posedge clk_i) begin
        if (a_re_i) begin
            a_rdata_o <= mem[a_addr_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (b_en_i && !b_we_i) begin
            b_rdata_o <= mem[b_addr_i];
        end
    end

endmodule

// File: rtl/instr_port.sv
// Instruction fetch front end
`timescale 1ns/100ps

module instr_port (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    // fetch request from the core
    input  logic [core_mem_pkg::IADDR_W-1:0]  addr_i,
    input  logic                              req_i,
    input  logic [3:0]                        be_i,
    output logic                              gnt_o,
    output logic                              rvalid_o,
    output logic [31:0]                       rdata_o,

    // RAM read port
    output logic                              ram_re_o,
    output logic [core_mem_pkg::MEM_AW-1:0]   ram_addr_o,
    input  logic [63:0]                       ram_rdata_i
);

    import core_mem_pkg::*;

    logic [IADDR_W-1:0] offset;
    logic               in_range;
    logic               valid_q;
    logic               half_q;
    logic               range_q;

    // byte offset into the RAM window
    assign offset   = addr_i - DRAM_BASE;
    assign in_range = (addr_i >= DRAM_BASE) && (offset < MEM_BYTES);

    // never stalls, every request is accepted in its own cycle
    assign gnt_o = req_i;

    // be_i is carried for interface compatibility, fetches return the full 32 bits
    assign ram_re_o   = req_i && in_range;
    assign ram_addr_o = offset[WORD_OFF_W +: MEM_AW];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i && gnt_o;
        end
    end

    // half select and range flag travel alongside the RAM read
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            half_q  <= addr_i[2];
            range_q <= in_range;
        end
    end

    assign rvalid_o = valid_q;
    assign rdata_o  = !range_q ? 32'h0 :
                      half_q   ? ram_rdata_i[63:32] : ram_rdata_i[31:0];

endmodule

// File: rtl/data_port.sv
// Data port front end
`timescale 1ns/100ps

module data_port (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    // request phase
    input  logic [core_mem_pkg::INDEX_W-1:0] index_i,
    input  logic [63:0]                      wdata_i,
    input  logic                             req_i,
    input  logic                             we_i,
    input  logic [7:0]                       be_i,
    output logic                             gnt_o,

    // tag phase
    input  logic [core_mem_pkg::TAG_W-1:0]   tag_i,
    input  logic                             tag_valid_i,
    input  logic                             kill_i,

    // read response
    output logic                             rvalid_o,
    output logic [63:0]                      rdata_o,

    // RAM read/write port
    output logic                             ram_en_o,
    output logic                             ram_we_o,
    output logic [7:0]                       ram_be_o,
    output logic [core_mem_pkg::MEM_AW-1:0]  ram_addr_o,
    output logic [63:0]                      ram_wdata_o,
    input  logic [63:0]                      ram_rdata_i
);

    import core_mem_pkg::*;

    typedef enum logic {
        IDLE,
        WAIT_TAG
    } state_e;

    state_e state_q;
    state_e state_d;

    // request held while the tag is outstanding
    logic [INDEX_W-1:0] index_q;
    logic               we_q;
    logic [7:0]         be_q;
    logic [63:0]        wdata_q;

    logic [PADDR_W-1:0] paddr;
    logic [PADDR_W-1:0] offset;
    logic               in_range;
    logic               accept;
    logic               tag_hit;

    logic               read_q;
    logic               range_q;

    // idle means ready for a new request
    assign gnt_o  = (state_q == IDLE);
    assign accept = req_i && gnt_o;

    // kill wins over a tag in the same cycle
    assign tag_hit = (state_q == WAIT_TAG) && tag_valid_i && !kill_i;

    // late tag joined with the stored index
    assign paddr    = {tag_i, index_q};
    assign offset   = paddr - PADDR_W'(DRAM_BASE);
    assign in_range = (paddr >= DRAM_BASE) && (offset < MEM_BYTES);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = WAIT_TAG;
                end
            end
            WAIT_TAG: begin
                if (tag_valid_i || kill_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            read_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // only reads produce a response
            read_q  <= tag_hit && !we_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            index_q <= index_i;
            we_q    <= we_i;
            be_q    <= be_i;
            wdata_q <= wdata_i;
        end
    end

    // zero-fill select for the returning word
    always_ff @(posedge clk_i) begin
        if (tag_hit) begin
            range_q <= in_range;
        end
    end

    // one RAM access per tag, nothing for out-of-range addresses
    assign ram_en_o    = tag_hit && in_range;
    assign ram_we_o    = we_q;
    assign ram_be_o    = be_q;
    assign ram_addr_o  = offset[WORD_OFF_W +: MEM_AW];
    assign ram_wdata_o = wdata_q;

    assign rvalid_o = read_q;
    assign rdata_o  = range_q ? ram_rdata_i : 64'h0;

endmodule

// File: rtl/core_mem.sv
// Core memory top level
`timescale 1ns/100ps

module core_mem (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    // instruction fetch port
    input  logic [core_mem_pkg::IADDR_W-1:0] instr_if_address_i,
    input  logic                             instr_if_data_req_i,
    input  logic [3:0]                       instr_if_data_be_i,
    output logic                             instr_if_data_gnt_o,
    output logic                             instr_if_data_rvalid_o,
    output logic [31:0]                      instr_if_data_rdata_o,

    // data port with late tag
    input  logic [core_mem_pkg::INDEX_W-1:0] data_if_address_index_i,
    input  logic [core_mem_pkg::TAG_W-1:0]   data_if_address_tag_i,
    input  logic [63:0]                      data_if_data_wdata_i,
    input  logic                             data_if_data_req_i,
    input  logic                             data_if_data_we_i,
    input  logic [7:0]                       data_if_data_be_i,
    input  logic                             data_if_kill_req_i,
    input  logic                             data_if_tag_valid_i,
    output logic                             data_if_data_gnt_o,
    output logic                             data_if_data_rvalid_o,
    output logic [63:0]                      data_if_data_rdata_o
);

    import core_mem_pkg::*;

    logic              instr_ram_re;
    logic [MEM_AW-1:0] instr_ram_addr;
    logic [63:0]       instr_ram_rdata;

    logic              data_ram_en;
    logic              data_ram_we;
    logic [7:0]        data_ram_be;
    logic [MEM_AW-1:0] data_ram_addr;
    logic [63:0]       data_ram_wdata;
    logic [63:0]       data_ram_rdata;

    instr_port instr_port_i (
        .clk_i       ( clk_i                  ),
        .rst_n_i     ( rst_n_i                ),
        .addr_i      ( instr_if_address_i     ),
        .req_i       ( instr_if_data_req_i    ),
        .be_i        ( instr_if_data_be_i     ),
        .gnt_o       ( instr_if_data_gnt_o    ),
        .rvalid_o    ( instr_if_data_rvalid_o ),
        .rdata_o     ( instr_if_data_rdata_o  ),
        .ram_re_o    ( instr_ram_re           ),
        .ram_addr_o  ( instr_ram_addr         ),
        .ram_rdata_i ( instr_ram_rdata        )
    );

    data_port data_port_i (
        .clk_i       ( clk_i                   ),
        .rst_n_i     ( rst_n_i                 ),
        .index_i     ( data_if_address_index_i ),
        .wdata_i     ( data_if_data_wdata_i    ),
        .req_i       ( data_if_data_req_i      ),
        .we_i        ( data_if_data_we_i       ),
        .be_i        ( data_if_data_be_i       ),
        .gnt_o       ( data_if_data_gnt_o      ),
        .tag_i       ( data_if_address_tag_i   ),
        .tag_valid_i ( data_if_tag_valid_i     ),
        .kill_i      ( data_if_kill_req_i      ),
        .rvalid_o    ( data_if_data_rvalid_o   ),
        .rdata_o     ( data_if_data_rdata_o    ),
        .ram_en_o    ( data_ram_en             ),
        .ram_we_o    ( data_ram_we             ),
        .ram_be_o    ( data_ram_be             ),
        .ram_addr_o  ( data_ram_addr           ),
        .ram_wdata_o ( data_ram_wdata          ),
        .ram_rdata_i ( data_ram_rdata          )
    );

    // fetches use port a, loads and stores use port b
    mem_ram #(
        .DEPTH ( MEM_WORDS )
    ) ram_i (
        .clk_i     ( clk_i           ),
        .a_re_i    ( instr_ram_re    ),
        .a_addr_i  ( instr_ram_addr  ),
        .a_rdata_o ( instr_ram_rdata ),
        .b_en_i    ( data_ram_en     ),
        .b_we_i    ( data_ram_we     ),
        .b_be_i    ( data_ram_be     ),
        .b_addr_i  ( data_ram_addr   ),
        .b_wdata_i ( data_ram_wdata  ),
        .b_rdata_o ( data_ram_rdata  )
    );

endmodule

// File: sim/core_mem_tb.sv
// Core memory testbench
`timescale 1ns/100ps

module core_mem_tb;

    import core_mem_pkg::*;

    localparam int NUM_OPS        = 400;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 8 + RESET_CYCLES;

    logic               clk_i;
    logic               rst_n_i;
    logic [IADDR_W-1:0] instr_if_address;
    logic               instr_if_data_req;
    logic [3:0]         instr_if_data_be;
    logic               instr_if_data_gnt_o;
    logic               instr_if_data_rvalid_o;
    logic [31:0]        instr_if_data_rdata_o;
    logic [INDEX_W-1:0] data_if_address_index;
    logic [TAG_W-1:0]   data_if_address_tag;
    logic [63:0]        data_if_data_wdata;
    logic               data_if_data_req;
    logic               data_if_data_we;
    logic [7:0]         data_if_data_be;
    logic               data_if_kill_req;
    logic               data_if_tag_valid;
    logic               data_if_data_gnt_o;
    logic               data_if_data_rvalid_o;
    logic [63:0]        data_if_data_rdata_o;

    int          seed = 92376;
    int          value_errors = 0;
    int          protocol_errors = 0;
    logic [63:0] model [int];

    // data port as the master sees it
    logic        busy;
    int          wait_cnt;
    int          ops_started;
    int          drain;

    // data request in flight
    logic        op_we;
    logic [63:0] op_addr;
    logic [7:0]  op_be;
    logic [63:0] op_wdata;
    int          op_delay;
    logic        op_kill;
    logic        op_both;

    // responses expected in the current cycle
    logic        exp_irv;
    logic [31:0] exp_irdata;
    logic        exp_drv;
    logic [63:0] exp_drdata;

    // values for the next cycle
    logic        next_ireq;
    logic [63:0] next_iaddr;
    logic [3:0]  next_ibe;
    logic        next_dreq;
    logic        next_tagv;
    logic        next_kill;

    core_mem dut_i (
        .clk_i                   ( clk_i                  ),
        .rst_n_i                 ( rst_n_i                ),
        .instr_if_address_i      ( instr_if_address       ),
        .instr_if_data_req_i     ( instr_if_data_req      ),
        .instr_if_data_be_i      ( instr_if_data_be       ),
        .instr_if_data_gnt_o     ( instr_if_data_gnt_o    ),
        .instr_if_data_rvalid_o  ( instr_if_data_rvalid_o ),
        .instr_if_data_rdata_o   ( instr_if_data_rdata_o  ),
        .data_if_address_index_i ( data_if_address_index  ),
        .data_if_address_tag_i   ( data_if_address_tag    ),
        .data_if_data_wdata_i    ( data_if_data_wdata     ),
        .data_if_data_req_i      ( data_if_data_req       ),
        .data_if_data_we_i       ( data_if_data_we        ),
        .data_if_data_be_i       ( data_if_data_be        ),
        .data_if_kill_req_i      ( data_if_kill_req       ),
        .data_if_tag_valid_i     ( data_if_tag_valid      ),
        .data_if_data_gnt_o      ( data_if_data_gnt_o     ),
        .data_if_data_rvalid_o   ( data_if_data_rvalid_o  ),
        .data_if_data_rdata_o    ( data_if_data_rdata_o   )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic mapped(input logic [63:0] addr);
        return (addr >= DRAM_BASE) && (addr < DRAM_BASE + 64'(MEM_WORDS) * 8);
    endfunction

    function automatic int word_index(input logic [63:0] addr);
        return int'((addr - DRAM_BASE) >> 3);
    endfunction

    function automatic logic [63:0] model_word(input int idx);
        if (model.exists(idx)) begin
            return model[idx];
        end
        return 64'h0;
    endfunction

    // small word pools at both ends of the RAM so reads revisit written words
    function automatic logic [63:0] random_addr();
        logic [63:0] addr;
        if (rand_below(10) == 0) begin
            if (rand_below(2) == 0) begin
                addr = DRAM_BASE - 64'(8 * (1 + rand_below(64)));
            end else begin
                addr = DRAM_BASE + 64'(MEM_WORDS) * 8 + 64'(8 * rand_below(64));
            end
        end else if (rand_below(2) == 0) begin
            addr = DRAM_BASE + 64'(rand_below(64)) * 8;
        end else begin
            addr = DRAM_BASE + 64'(MEM_WORDS - 1 - rand_below(64)) * 8;
        end
        addr[2:0] = 3'(rand_below(8));
        return addr;
    endfunction

    task automatic check(input string name, input logic [63:0] exp_val,
                         input logic [63:0] act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] %s expected %h got %h at %0t ns", name, exp_val, act_val, $time);
            value_errors++;
        end
    endtask

    task automatic check_outputs();
        check("instr_if_data_gnt_o", 64'(instr_if_data_req), 64'(instr_if_data_gnt_o));
        check("data_if_data_gnt_o", 64'(!busy), 64'(data_if_data_gnt_o));
        if (instr_if_data_rvalid_o !== exp_irv) begin
            $display("instruction rvalid %s at %0t ns",
                     exp_irv ? "missing" : "arrived with no fetch outstanding", $time);
            protocol_errors++;
        end else if (exp_irv) begin
            check("instr_if_data_rdata_o", 64'(exp_irdata), 64'(instr_if_data_rdata_o));
        end
        if (data_if_data_rvalid_o !== exp_drv) begin
            $display("data rvalid %s at %0t ns",
                     exp_drv ? "missing" : "arrived with no read outstanding", $time);
            protocol_errors++;
        end else if (exp_drv) begin
            check("data_if_data_rdata_o", exp_drdata, data_if_data_rdata_o);
        end
    endtask

    // what the coming rising edge does, applied to the model
    task automatic process_edge();
        logic        acc;
        logic        hit;
        logic        kil;
        logic [63:0] word;
        int          idx;
        // a fetch sees the memory before a store at the same edge
        exp_irv    = instr_if_data_req;
        exp_irdata = 32'h0;
        if (instr_if_data_req && mapped(instr_if_address)) begin
            word       = model_word(word_index(instr_if_address));
            exp_irdata = instr_if_address[2] ? word[63:32] : word[31:0];
        end
        acc = data_if_data_req && !busy;
        hit = busy && data_if_tag_valid && !data_if_kill_req;
        kil = busy && data_if_kill_req;
        exp_drv    = hit && !op_we;
        exp_drdata = 64'h0;
        if (hit && mapped(op_addr)) begin
            idx = word_index(op_addr);
            if (op_we) begin
                word = model_word(idx);
                for (int i = 0; i < 8; i++) begin
                    if (op_be[i]) begin
                        word[i*8 +: 8] = op_wdata[i*8 +: 8];
                    end
                end
                model[idx] = word;
            end else begin
                exp_drdata = model_word(idx);
            end
        end
        if (acc) begin
            busy     = 1'b1;
            wait_cnt = op_delay;
        end else if (hit || kil) begin
            busy = 1'b0;
        end
    endtask

    task automatic plan_next();
        next_dreq = 1'b0;
        next_tagv = 1'b0;
        next_kill = 1'b0;
        if (busy) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                next_kill = op_kill;
                next_tagv = !op_kill || op_both;
            end
        end else if (ops_started < NUM_OPS && rand_below(5) != 0) begin
            op_we     = (rand_below(2) == 1);
            op_addr   = random_addr();
            op_be     = 8'($random(seed));
            op_wdata  = {32'($random(seed)), 32'($random(seed))};
            op_delay  = 1 + rand_below(3);
            op_kill   = (rand_below(10) == 0);
            op_both   = (rand_below(2) == 1);
            next_dreq = 1'b1;
            ops_started++;
        end
        if (ops_started == NUM_OPS && !busy && !next_dreq) begin
            drain++;
        end
        next_ireq  = (drain == 0) && (rand_below(10) < 7);
        next_iaddr = random_addr();
        next_ibe   = 4'($random(seed));
    endtask

    task automatic drive_inputs();
        instr_if_data_req     <= next_ireq;
        instr_if_address      <= next_iaddr;
        instr_if_data_be      <= next_ibe;
        data_if_data_req      <= next_dreq;
        // request fields are valid only with req, the port must use its own copy
        if (next_dreq) begin
            data_if_data_we       <= op_we;
            data_if_data_be       <= op_be;
            data_if_data_wdata    <= op_wdata;
            data_if_address_index <= op_addr[INDEX_W-1:0];
        end else begin
            data_if_data_we       <= 1'($random(seed));
            data_if_data_be       <= 8'($random(seed));
            data_if_data_wdata    <= {32'($random(seed)), 32'($random(seed))};
            data_if_address_index <= INDEX_W'($random(seed));
        end
        // the tag only counts in its valid cycle
        if (next_tagv) begin
            data_if_address_tag <= op_addr[PADDR_W-1:INDEX_W];
        end else begin
            data_if_address_tag <= {12'($random(seed)), 32'($random(seed))};
        end
        data_if_tag_valid     <= next_tagv;
        data_if_kill_req      <= next_kill;
    endtask

    initial begin
        rst_n_i = 1'b0;
        instr_if_address = '0;
        instr_if_data_req = 1'b0;
        instr_if_data_be = '0;
        data_if_address_index = '0;
        data_if_address_tag = '0;
        data_if_data_wdata = '0;
        data_if_data_req = 1'b0;
        data_if_data_we = 1'b0;
        data_if_data_be = '0;
        data_if_kill_req = 1'b0;
        data_if_tag_valid = 1'b0;
        busy = 1'b0;
        ops_started = 0;
        drain = 0;
        exp_irv = 1'b0;
        exp_drv = 1'b0;
        op_addr = '0;
        op_we = 1'b0;
        op_be = '0;
        op_wdata = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        while (drain < 3) begin
            @(negedge clk_i);
            check_outputs();
            process_edge();
            plan_next();
            @(posedge clk_i);
            drive_inputs();
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: core_mem.f
rtl/core_mem_pkg.sv
rtl/mem_ram.sv
rtl/instr_port.sv
rtl/data_port.sv
rtl/core_mem.sv
sim/core_mem_tb.sv

// File: Makefile
TOP = core_mem_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

obj_dir/V$(TOP): core_mem.f rtl/*.sv sim/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f core_mem.f

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir
